//--- design/uart_dbg_pkg.sv
`default_nettype none

package uart_dbg_pkg;

  ////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////

  typedef logic [7:0] byte_t;
  typedef logic [7:0] mem_addr_t;
  typedef logic [7:0] len_t;

  // UART bit time in clock cycles
  localparam int unsigned CLKS_PER_BIT = 8;
  localparam int unsigned BAUD_CNT_W   = $clog2(CLKS_PER_BIT);

  typedef logic [BAUD_CNT_W-1:0] baud_cnt_t;

  localparam baud_cnt_t BAUD_LAST = baud_cnt_t'(CLKS_PER_BIT - 1);
  localparam baud_cnt_t BAUD_HALF = baud_cnt_t'(CLKS_PER_BIT / 2 - 1);

  ////////////////////////////////////////
  // Debug protocol
  ////////////////////////////////////////

  localparam byte_t CMD_READ  = 8'h11;
  localparam byte_t CMD_WRITE = 8'h12;
  localparam byte_t CMD_EXEC  = 8'h13;
  localparam byte_t RSP_ACK   = 8'h06;
  localparam byte_t RSP_EOT   = 8'h04;

  localparam int unsigned MEM_DEPTH = 256;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ADDR,
    ST_LEN,
    ST_ACK,
    ST_XFER,
    ST_EOT
  } engine_state_t;

endpackage

`default_nettype wire

//--- design/mem_port_if.sv
`timescale 1ns/1ns
`default_nettype none

interface mem_port_if;
  import uart_dbg_pkg::*;

  logic      en;
  logic      we;
  mem_addr_t addr;
  byte_t     wdata;
  byte_t     rdata;

  // Command engine side
  modport master (
    output en, we, addr, wdata,
    input  rdata
  );

  // Memory side
  modport slave (
    input  en, we, addr, wdata,
    output rdata
  );

endinterface

`default_nettype wire

//--- design/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                rx_i,
  output logic                rx_valid_o,
  output uart_dbg_pkg::byte_t rx_data_o,
  input  logic                rx_ready_i
);
  import uart_dbg_pkg::*;

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

  rx_state_t state_q;
  logic      rx_meta_q;
  logic      rx_sync_q;
  logic      rx_prev_q;
  baud_cnt_t baud_cnt_q;
  logic      bit_tick;
  logic [2:0] bit_idx_q;
  byte_t     shift_q;

  // Two-flop synchronizer plus a delayed copy for the start edge
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      rx_prev_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
      rx_prev_q <= rx_sync_q;
    end
  end

  assign bit_tick = (baud_cnt_q == BAUD_LAST);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q    <= RX_IDLE;
      baud_cnt_q <= '0;
      bit_idx_q  <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      if (rx_valid_o && rx_ready_i) begin
        rx_valid_o <= 1'b0;
      end
      baud_cnt_q <= baud_cnt_q + baud_cnt_t'(1);
      case (state_q)
        RX_IDLE: begin
          baud_cnt_q <= '0;
          if (rx_prev_q && !rx_sync_q) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          // Recheck the start bit at its middle to reject glitches
          if (baud_cnt_q == BAUD_HALF) begin
            baud_cnt_q <= '0;
            bit_idx_q  <= '0;
            state_q    <= rx_sync_q ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (bit_tick) begin
            baud_cnt_q <= '0;
            bit_idx_q  <= bit_idx_q + 3'd1;
            if (bit_idx_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          // A low stop bit drops the frame; a new byte overwrites an untaken one
          if (bit_tick) begin
            state_q <= RX_IDLE;
            if (rx_sync_q) begin
              rx_valid_o <= 1'b1;
            end
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // LSB first, so shift in from the top
  always_ff @(posedge clk) begin
    if (state_q == RX_DATA && bit_tick) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
    if (state_q == RX_STOP && bit_tick && rx_sync_q) begin
      rx_data_o <= shift_q;
    end
  end

endmodule

`default_nettype wire

//--- design/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                tx_valid_i,
  input  uart_dbg_pkg::byte_t tx_data_i,
  output logic                tx_ready_o,
  output logic                tx_o
);
  import uart_dbg_pkg::*;

  logic       busy_q;
  logic [9:0] frame_q;
  baud_cnt_t  baud_cnt_q;
  logic [3:0] bit_cnt_q;

  assign tx_ready_o = !busy_q;

  // Frame register shifts in ones, so the line rests high when idle
  assign tx_o = frame_q[0];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      busy_q     <= 1'b0;
      frame_q    <= '1;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
    end else if (!busy_q) begin
      if (tx_valid_i) begin
        // Stop, data LSB first, start
        frame_q    <= {1'b1, tx_data_i, 1'b0};
        busy_q     <= 1'b1;
        baud_cnt_q <= '0;
        bit_cnt_q  <= '0;
      end
    end else begin
      if (baud_cnt_q == BAUD_LAST) begin
        baud_cnt_q <= '0;
        frame_q    <= {1'b1, frame_q[9:1]};
        if (bit_cnt_q == 4'd9) begin
          busy_q <= 1'b0;
        end else begin
          bit_cnt_q <= bit_cnt_q + 4'd1;
        end
      end else begin
        baud_cnt_q <= baud_cnt_q + baud_cnt_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

//--- design/dbg_mem.sv
`timescale 1ns/1ns
`default_nettype none

module dbg_mem (
  input  logic       clk,
  mem_port_if.slave  mem
);
  import uart_dbg_pkg::*;

  byte_t ram_q [MEM_DEPTH];

  // Single port; a read returns its byte on the next cycle
  always_ff @(posedge clk) begin
    if (mem.en) begin
      if (mem.we) begin
        ram_q[mem.addr] <= mem.wdata;
      end else begin
        mem.rdata <= ram_q[mem.addr];
      end
    end
  end

endmodule

`default_nettype wire

//--- design/dbg_cmd_engine.sv
`timescale 1ns/1ns
`default_nettype none

module dbg_cmd_engine (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    rx_valid_i,
  input  uart_dbg_pkg::byte_t     rx_data_i,
  output logic                    rx_ready_o,
  output logic                    tx_valid_o,
  output uart_dbg_pkg::byte_t     tx_data_o,
  input  logic                    tx_ready_i,
  mem_port_if.master              mem,
  output logic                    exec_valid_o,
  output uart_dbg_pkg::mem_addr_t exec_addr_o
);
  import uart_dbg_pkg::*;

  engine_state_t state_q;
  byte_t         cmd_q;
  mem_addr_t     addr_q;
  len_t          rem_q;
  logic          rd_pend_q;  // rdata holds the byte at addr_q
  logic          rx_fire;
  logic          tx_fire;
  logic          is_read;
  logic          step;

  assign rx_fire = rx_valid_i && rx_ready_o;
  assign tx_fire = tx_valid_o && tx_ready_i;
  assign is_read = (cmd_q == CMD_READ);

  // One data byte moved in the transfer loop
  assign step = (state_q == ST_XFER) && (is_read ? tx_fire : rx_fire);

  ////////////////////////////////////////
  // Handshakes and memory port
  ////////////////////////////////////////

  always_comb begin
    rx_ready_o = 1'b0;
    tx_valid_o = 1'b0;
    tx_data_o  = RSP_ACK;
    mem.en     = 1'b0;
    mem.we     = 1'b0;
    case (state_q)
      ST_IDLE, ST_ADDR, ST_LEN: rx_ready_o = 1'b1;
      ST_ACK: tx_valid_o = 1'b1;
      ST_XFER: begin
        if (is_read) begin
          // Fetch first, then offer rdata until the transmitter takes it
          mem.en     = !rd_pend_q;
          tx_valid_o = rd_pend_q;
          tx_data_o  = mem.rdata;
        end else begin
          rx_ready_o = 1'b1;
          mem.en     = rx_valid_i;
          mem.we     = rx_valid_i;
        end
      end
      ST_EOT: begin
        tx_valid_o = 1'b1;
        tx_data_o  = RSP_EOT;
      end
      default: ;
    endcase
  end

  assign mem.addr  = addr_q;
  assign mem.wdata = rx_data_i;

  // Pulse in the cycle the exec ACK goes to the transmitter
  assign exec_valid_o = (state_q == ST_ACK) && (cmd_q == CMD_EXEC) && tx_ready_i;

  ////////////////////////////////////////
  // Protocol FSM
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q     <= ST_IDLE;
      rd_pend_q   <= 1'b0;
      exec_addr_o <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (rx_fire) begin
            case (rx_data_i)
              CMD_READ, CMD_WRITE, CMD_EXEC: state_q <= ST_ADDR;
              RSP_ACK: state_q <= ST_ACK;
              default: ;
            endcase
          end
        end
        ST_ADDR: begin
          if (rx_fire) begin
            if (cmd_q == CMD_EXEC) begin
              exec_addr_o <= rx_data_i;
              state_q     <= ST_ACK;
            end else begin
              state_q <= ST_LEN;
            end
          end
        end
        ST_LEN: begin
          if (rx_fire) begin
            state_q <= ST_ACK;
          end
        end
        ST_ACK: begin
          // Challenge and exec end with the ACK
          if (tx_fire) begin
            if (cmd_q == RSP_ACK || cmd_q == CMD_EXEC) begin
              state_q <= ST_IDLE;
            end else if (rem_q == '0) begin
              state_q <= ST_EOT;
            end else begin
              state_q <= ST_XFER;
            end
          end
        end
        ST_XFER: begin
          if (is_read && !rd_pend_q) begin
            rd_pend_q <= 1'b1;
          end
          if (step) begin
            rd_pend_q <= 1'b0;
            if (rem_q == len_t'(1)) begin
              state_q <= ST_EOT;
            end
          end
        end
        ST_EOT: begin
          if (tx_fire) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Command, address and byte count
  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && rx_fire) begin
      cmd_q <= rx_data_i;
    end
    if (state_q == ST_ADDR && rx_fire) begin
      addr_q <= rx_data_i;
    end
    if (state_q == ST_LEN && rx_fire) begin
      rem_q <= rx_data_i;
    end
    // Address wraps at the top of memory
    if (step) begin
      addr_q <= addr_q + mem_addr_t'(1);
      rem_q  <= rem_q - len_t'(1);
    end
  end

endmodule

`default_nettype wire

//--- design/uart_dbg_top.sv
`timescale 1ns/1ns
`default_nettype none

module uart_dbg_top (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    uart_rx_i,
  output logic                    uart_tx_o,
  output logic                    exec_valid_o,
  output uart_dbg_pkg::mem_addr_t exec_addr_o
);
  import uart_dbg_pkg::*;

  // Received byte stream
  logic  rx_valid;
  byte_t rx_data;
  logic  rx_ready;

  // Transmitted byte stream
  logic  tx_valid;
  byte_t tx_data;
  logic  tx_ready;

  mem_port_if mem_bus ();

  uart_rx i_uart_rx (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .rx_i       (uart_rx_i),
    .rx_valid_o (rx_valid),
    .rx_data_o  (rx_data),
    .rx_ready_i (rx_ready)
  );

  uart_tx i_uart_tx (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .tx_valid_i (tx_valid),
    .tx_data_i  (tx_data),
    .tx_ready_o (tx_ready),
    .tx_o       (uart_tx_o)
  );

  dbg_mem i_dbg_mem (
    .clk (clk),
    .mem (mem_bus.slave)
  );

  dbg_cmd_engine i_dbg_cmd_engine (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .rx_valid_i   (rx_valid),
    .rx_data_i    (rx_data),
    .rx_ready_o   (rx_ready),
    .tx_valid_o   (tx_valid),
    .tx_data_o    (tx_data),
    .tx_ready_i   (tx_ready),
    .mem          (mem_bus.master),
    .exec_valid_o (exec_valid_o),
    .exec_addr_o  (exec_addr_o)
  );

endmodule

`default_nettype wire

//--- test/uart_dbg_sva.sv
`timescale 1ns/1ns
`default_nettype none

module uart_dbg_sva (
  input logic                clk,
  input logic                rst_n_i,
  input logic                exec_valid_i,
  input logic                uart_tx_i,
  input logic                tx_valid_i,
  input logic                tx_ready_i,
  input uart_dbg_pkg::byte_t tx_data_i
);

  // Counts failed properties for the testbench monitor
  int unsigned assert_fail_cnt = 0;

  // Exec is a single-cycle strobe
  exec_single_pulse: assert property (
    @(posedge clk) disable iff (!rst_n_i) exec_valid_i |=> !exec_valid_i
  ) else begin
    assert_fail_cnt++;
    $error("exec_valid_o stayed high for two cycles");
  end

  // Idle transmitter keeps the line at mark level
  tx_idle_high: assert property (
    @(posedge clk) disable iff (!rst_n_i) tx_ready_i |-> uart_tx_i
  ) else begin
    assert_fail_cnt++;
    $error("uart_tx_o low while the transmitter is idle");
  end

  // Offered byte must not change until the transmitter takes it
  tx_data_hold: assert property (
    @(posedge clk) disable iff (!rst_n_i) tx_valid_i && !tx_ready_i |=> $stable(tx_data_i)
  ) else begin
    assert_fail_cnt++;
    $error("tx_data changed while waiting for tx_ready");
  end

endmodule

bind uart_dbg_top uart_dbg_sva i_sva (
  .clk          (clk),
  .rst_n_i      (rst_n_i),
  .exec_valid_i (exec_valid_o),
  .uart_tx_i    (uart_tx_o),
  .tx_valid_i   (tx_valid),
  .tx_ready_i   (tx_ready),
  .tx_data_i    (tx_data)
);

`default_nettype wire

//--- test/uart_dbg_tb.sv
`timescale 1ns/1ns
`default_nettype none

module uart_dbg_tb;
  import uart_dbg_pkg::*;

  localparam int unsigned RESET_CYCLES = 16;
  localparam int unsigned NUM_TESTS    = 14;
  localparam int unsigned QUIET_FRAMES = 2;
  localparam logic [31:0] SEED         = 32'ha8a7_fc38;

  typedef enum logic [2:0] {
    OP_ACK, OP_WRITE, OP_READ, OP_EXEC, OP_JUNK, OP_BADSTOP
  } op_t;

  typedef struct packed {
    op_t       op;
    mem_addr_t addr;
    len_t      len;
    mem_addr_t exec_addr;
  } test_entry_t;

  logic        clk = 1'b0;
  logic        rst_n_i;
  logic        uart_rx_i;
  logic        uart_tx_o;
  logic        exec_valid_o;
  mem_addr_t   exec_addr_o;

  test_entry_t tests [NUM_TESTS];
  byte_t       ref_mem [MEM_DEPTH];
  byte_t       resp_q [$];
  int unsigned exec_count = 0;
  int unsigned cycle_cnt = 0;
  int unsigned timeout_limit;

  uart_dbg_top DUT (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .uart_rx_i    (uart_rx_i),
    .uart_tx_o    (uart_tx_o),
    .exec_valid_o (exec_valid_o),
    .exec_addr_o  (exec_addr_o)
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("MISMATCH at %0t ns: %s got 0x%0h, expected 0x%0h",
                         $time, name, actual, expected));
    end
  endtask

  ////////////////////////////////////////
  // Host UART model
  ////////////////////////////////////////

  task automatic send_frame(input byte_t data, input logic stop_bit);
    logic [10:0] bits;
    int          i;
    // Start, data LSB first, stop, one idle bit
    bits = {1'b1, stop_bit, data, 1'b0};
    for (i = 0; i < 11; i++) begin
      @(posedge clk);
      uart_rx_i <= bits[i];
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  task automatic recv_frame(output byte_t data, output logic stop_bit);
    int i;
    @(negedge clk);
    while (uart_tx_o !== 1'b0) @(negedge clk);
    // Move to the middle of the start bit
    repeat (CLKS_PER_BIT / 2) @(negedge clk);
    for (i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      data[i] = uart_tx_o;
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    stop_bit = uart_tx_o;
  endtask

  task automatic expect_byte(input byte_t expected);
    byte_t actual;
    while (resp_q.size() == 0) @(posedge clk);
    actual = resp_q.pop_front();
    check_value("uart_tx_o response byte", 32'(actual), 32'(expected));
  endtask

  task automatic expect_silence();
    repeat (QUIET_FRAMES * 10 * CLKS_PER_BIT) @(posedge clk);
    check_value("uart_tx_o pending byte count", 32'(resp_q.size()), 32'd0);
  endtask

  function automatic int unsigned entry_frames(input test_entry_t t);
    case (t.op)
      OP_ACK:            return 2;
      OP_WRITE, OP_READ: return 32'd5 + 32'(t.len);
      OP_EXEC:           return 3;
      default:           return 1 + QUIET_FRAMES;
    endcase
  endfunction

  task automatic run_entry(input test_entry_t t);
    int          i;
    byte_t       data;
    mem_addr_t   addr;
    int unsigned exec_before;
    exec_before = exec_count;
    case (t.op)
      OP_ACK: begin
        send_frame(RSP_ACK, 1'b1);
        expect_byte(RSP_ACK);
      end
      OP_WRITE: begin
        send_frame(CMD_WRITE, 1'b1);
        send_frame(t.addr, 1'b1);
        send_frame(t.len, 1'b1);
        expect_byte(RSP_ACK);
        for (i = 0; i < int'(t.len); i++) begin
          data = byte_t'($urandom());
          addr = t.addr + mem_addr_t'(i);
          ref_mem[addr] = data;
          send_frame(data, 1'b1);
        end
        expect_byte(RSP_EOT);
      end
      OP_READ: begin
        send_frame(CMD_READ, 1'b1);
        send_frame(t.addr, 1'b1);
        send_frame(t.len, 1'b1);
        expect_byte(RSP_ACK);
        for (i = 0; i < int'(t.len); i++) begin
          addr = t.addr + mem_addr_t'(i);
          expect_byte(ref_mem[addr]);
        end
        expect_byte(RSP_EOT);
      end
      OP_EXEC: begin
        send_frame(CMD_EXEC, 1'b1);
        send_frame(t.addr, 1'b1);
        expect_byte(RSP_ACK);
        @(negedge clk);
        check_value("exec_addr_o", 32'(exec_addr_o), 32'(t.exec_addr));
      end
      OP_JUNK: begin
        send_frame(8'h55, 1'b1);
        expect_silence();
      end
      default: begin
        // Challenge byte with a broken stop bit
        send_frame(RSP_ACK, 1'b0);
        expect_silence();
      end
    endcase
    check_value("exec_valid_o pulse count", 32'(exec_count - exec_before),
                (t.op == OP_EXEC) ? 32'd1 : 32'd0);
  endtask

  ////////////////////////////////////////
  // Monitors
  ////////////////////////////////////////

  initial begin : collect_responses
    byte_t data;
    logic  stop_bit;
    @(posedge rst_n_i);
    forever begin
      recv_frame(data, stop_bit);
      check_value("uart_tx_o stop bit", 32'(stop_bit), 32'd1);
      resp_q.push_back(data);
    end
  end

  always @(negedge clk) begin
    if (rst_n_i === 1'b1 && exec_valid_o === 1'b1) begin
      exec_count <= exec_count + 1;
    end
  end

  always @(negedge clk) begin
    if (DUT.i_sva.assert_fail_cnt != 0) begin
      fail_run("Bound assertion checker reported a failure");
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_limit) begin
      fail_run("Timeout: the DUT did not finish the test sequence in time");
    end
  end

  initial begin
    int unsigned total_frames;
    int          idx;
    rst_n_i   <= 1'b0;
    uart_rx_i <= 1'b1;
    void'($urandom(SEED));
    // op, address, length, expected exec address
    tests = '{
      '{OP_ACK,     8'h00, 8'd0, 8'h00},
      '{OP_WRITE,   8'h10, 8'd4, 8'h00},
      '{OP_READ,    8'h10, 8'd4, 8'h00},
      '{OP_WRITE,   8'hFD, 8'd6, 8'h00},
      '{OP_READ,    8'hFD, 8'd6, 8'h00},
      '{OP_WRITE,   8'h40, 8'd0, 8'h00},
      '{OP_READ,    8'h40, 8'd0, 8'h00},
      '{OP_EXEC,    8'h3C, 8'd0, 8'h3C},
      '{OP_JUNK,    8'h00, 8'd0, 8'h00},
      '{OP_ACK,     8'h00, 8'd0, 8'h00},
      '{OP_BADSTOP, 8'h00, 8'd0, 8'h00},
      '{OP_ACK,     8'h00, 8'd0, 8'h00},
      '{OP_READ,    8'h12, 8'd2, 8'h00},
      '{OP_EXEC,    8'hA5, 8'd0, 8'hA5}
    };
    total_frames = QUIET_FRAMES;
    for (idx = 0; idx < NUM_TESTS; idx++) begin
      total_frames = total_frames + entry_frames(tests[idx]);
    end
    timeout_limit = total_frames * 10 * CLKS_PER_BIT * 2 + RESET_CYCLES;

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n_i <= 1'b1;
    @(negedge clk);
    check_value("uart_tx_o idle level", 32'(uart_tx_o), 32'd1);
    check_value("exec_valid_o after reset", 32'(exec_valid_o), 32'd0);

    for (idx = 0; idx < NUM_TESTS; idx++) begin
      run_entry(tests[idx]);
    end
    expect_silence();
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

//--- uart_dbg_top.f
design/uart_dbg_pkg.sv
design/mem_port_if.sv
design/uart_rx.sv
design/uart_tx.sv
design/dbg_mem.sv
design/dbg_cmd_engine.sv
design/uart_dbg_top.sv
test/uart_dbg_sva.sv
test/uart_dbg_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the UART debug testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
if ! verilator --binary --timing --assert --top-module uart_dbg_tb \
    -f uart_dbg_top.f -o uart_dbg_sim; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/uart_dbg_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^NO ERRORS$" sim.log; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1
